// ==== rename_dispatch.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/rename_pkg.sv
rtl/inst_decoder.sv
rtl/map_table.sv
rtl/tag_fifo.sv
rtl/init_counter.sv
rtl/dispatch_fsm.sv
rtl/dispatch_stage.sv
rtl/rename_dispatch.sv
testbench/tb_rename_dispatch.sv

// ==== rtl/dispatch_fsm.sv ====
/*
 * dispatch control FSM
 * init fill, run, drain after halt,
 * then halted once the ROB is empty
 */
module dispatch_fsm
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        init_done_i,
    input  logic        halt_dispatched_i,
    input  logic        rob_empty_i,
    output logic        count_en_o,
    output logic        init_push_o,
    output logic        run_o,
    output disp_state_e state_o
);

    disp_state_e state_q;
    disp_state_e state_d;

    // ==============================
    // next state
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            INIT: begin
                if (init_done_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (halt_dispatched_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // wait for the halt itself to retire
                if (rob_empty_i) begin
                    state_d = HALTED;
                end
            end
            default: state_d = HALTED;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state_q <= INIT;
        end else begin
            state_q <= state_d;
        end
    end

    // fill the free list until the counter is done
    assign count_en_o  = (state_q == INIT) && !init_done_i;
    assign init_push_o = count_en_o;
    assign run_o       = (state_q == RUN);
    assign state_o     = state_q;

endmodule

// ==== rtl/dispatch_stage.sv ====
/*
 * rename and dispatch of one instruction
 * decodes, takes a free tag, records the ROB
 * entry and registers the RS entry
 * stall covers state, free list, ROB and RS credits
 */
`include "rename_config.svh"

module dispatch_stage
    import isa_pkg::*;
    import rename_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          fetch_valid_i,
    input  fetch_packet_t fetch_packet_i,
    input  logic          run_i,
    input  logic          issue_i,
    input  logic          free_empty_i,
    input  phys_tag_t     free_tag_i,
    output logic          free_pop_o,
    output arch_reg_t     src1_arch_o,
    output arch_reg_t     src2_arch_o,
    input  phys_tag_t     src1_tag_i,
    input  phys_tag_t     src2_tag_i,
    input  logic          src1_ready_i,
    input  logic          src2_ready_i,
    output arch_reg_t     dest_arch_o,
    input  phys_tag_t     old_tag_i,
    output logic          rename_o,
    input  logic          rob_full_i,
    input  rob_idx_t      rob_idx_i,
    output logic          rob_push_o,
    output rob_entry_t    rob_entry_o,
    output logic          rs_valid_o,
    output rs_entry_t     rs_entry_o,
    output logic          halt_o,
    output logic          stall_o
);

    decode_t                    dec;
    logic                       accept;
    logic                       dest_wen;
    logic [11:0]                imm;
    logic [$clog2(`RS_SLOTS):0] credit_q;
    rs_entry_t                  rs_next;
    rs_entry_t                  rs_q;
    logic                       rs_valid_q;

    inst_decoder i_inst_decoder (
        .inst_i   (fetch_packet_i.inst),
        .decode_o (dec)
    );

    // ==============================
    // rename control
    // ==============================
    assign src1_arch_o = fetch_packet_i.inst.r.rs1;
    assign src2_arch_o = fetch_packet_i.inst.r.rs2;
    assign dest_arch_o = fetch_packet_i.inst.r.rd;

    assign stall_o  = !run_i || free_empty_i || rob_full_i || (credit_q == '0);
    assign accept   = fetch_valid_i && !stall_o;
    // x0 writes take no tag
    assign dest_wen = dec.has_dest && (fetch_packet_i.inst.r.rd != '0);

    assign free_pop_o = accept && dest_wen;
    assign rename_o   = free_pop_o;
    assign rob_push_o = accept;
    assign halt_o     = accept && dec.halt;

    always_comb begin
        rob_entry_o.dest_arch = dest_wen ? fetch_packet_i.inst.r.rd : '0;
        rob_entry_o.old_tag   = dest_wen ? old_tag_i : '0;
        rob_entry_o.new_tag   = dest_wen ? free_tag_i : '0;
    end

    // low 12 immediate bits per format
    always_comb begin
        if (dec.wr_mem || dec.cond_branch) begin
            imm = {fetch_packet_i.inst.s.imm_hi, fetch_packet_i.inst.s.imm_lo};
        end else if (fetch_packet_i.inst.u.opcode == OPC_LUI) begin
            imm = fetch_packet_i.inst.u.imm[11:0];
        end else begin
            imm = fetch_packet_i.inst.i.imm;
        end
    end

    // unused source reads as tag 0, ready
    always_comb begin
        rs_next.rob_idx    = rob_idx_i;
        rs_next.dest_tag   = dest_wen ? free_tag_i : '0;
        rs_next.dest_wen   = dest_wen;
        rs_next.src1_tag   = dec.uses_src1 ? src1_tag_i : '0;
        rs_next.src1_ready = dec.uses_src1 ? src1_ready_i : 1'b1;
        rs_next.src2_tag   = dec.uses_src2 ? src2_tag_i : '0;
        rs_next.src2_ready = dec.uses_src2 ? src2_ready_i : 1'b1;
        rs_next.fu_type    = dec.fu_type;
        rs_next.imm        = imm;
    end

    // ==============================
    // RS credits and output register
    // ==============================
    always_ff @(posedge clock) begin
        if (!reset) begin
            credit_q   <= `RS_SLOTS;
            rs_valid_q <= 1'b0;
        end else begin
            rs_valid_q <= accept;
            case ({accept, issue_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rs_q <= rs_next;
        end
    end

    assign rs_valid_o = rs_valid_q;
    assign rs_entry_o = rs_q;

    // fetch honors stall, no back-pressure path exists
    a_no_fetch_on_stall: assert property (@(posedge clock) disable iff (!reset)
        fetch_valid_i |-> !stall_o);

endmodule

// ==== rtl/init_counter.sv ====
/*
 * free list fill counter
 * walks the tags above the architectural range
 * and flags when the last one is out
 */
`include "rename_config.svh"

module init_counter
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      count_en_i,
    output phys_tag_t tag_o,
    output logic      done_o
);

    phys_tag_t count_q;
    logic      done_q;

    assign tag_o  = count_q;
    assign done_o = done_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count_q <= phys_tag_t'(`ARCH_REGS);
            done_q  <= 1'b0;
        end else if (count_en_i && !done_q) begin
            // last tag sets done and holds
            if (count_q == phys_tag_t'(`PHYS_REGS - 1)) begin
                done_q <= 1'b1;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/inst_decoder.sv ====
/*
 * RV32I subset decoder
 * maps opcode and funct3 onto unit type,
 * memory flags and register use flags
 */
module inst_decoder
    import isa_pkg::*;
(
    input  inst_t   inst_i,
    output decode_t decode_o
);

    always_comb begin
        decode_o = '0;
        decode_o.fu_type = FU_ALU;
        case (inst_i.r.opcode)
            OPC_OP: begin
                decode_o.has_dest  = 1'b1;
                decode_o.uses_src1 = 1'b1;
                decode_o.uses_src2 = 1'b1;
                // only add/sub style funct7 codes
                decode_o.illegal   = !(inst_i.r.funct7 inside {7'h00, 7'h20});
            end
            OPC_OP_IMM: begin
                decode_o.has_dest  = 1'b1;
                decode_o.uses_src1 = 1'b1;
            end
            OPC_LOAD: begin
                decode_o.has_dest  = 1'b1;
                decode_o.uses_src1 = 1'b1;
                decode_o.rd_mem    = 1'b1;
                decode_o.fu_type   = FU_MEM;
                // lb lh lw lbu lhu
                decode_o.illegal   = inst_i.i.funct3 inside {3'b011, 3'b110, 3'b111};
            end
            OPC_STORE: begin
                decode_o.uses_src1 = 1'b1;
                decode_o.uses_src2 = 1'b1;
                decode_o.wr_mem    = 1'b1;
                decode_o.fu_type   = FU_MEM;
                // sb sh sw only
                decode_o.illegal   = inst_i.s.funct3 > 3'b010;
            end
            OPC_BRANCH: begin
                decode_o.uses_src1   = 1'b1;
                decode_o.uses_src2   = 1'b1;
                decode_o.cond_branch = 1'b1;
                decode_o.fu_type     = FU_BRANCH;
                decode_o.illegal     = inst_i.s.funct3 inside {3'b010, 3'b011};
            end
            OPC_LUI: begin
                decode_o.has_dest = 1'b1;
            end
            OPC_SYSTEM: begin
                // ebreak stops the machine, nothing else supported
                decode_o.halt    = (inst_i.i.funct3 == 3'b000) && (inst_i.i.imm == 12'h001);
                decode_o.illegal = !decode_o.halt;
            end
            default: begin
                decode_o.illegal = 1'b1;
            end
        endcase
        // illegal ops never write a register
        if (decode_o.illegal) begin
            decode_o.has_dest = 1'b0;
        end
    end

endmodule

// ==== rtl/isa_pkg.sv ====
/*
 * RV32I subset definitions
 * instruction formats, major opcodes and the
 * control word produced by the decoder
 */
package isa_pkg;

    // ==============================
    // instruction formats
    // ==============================
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } inst_t;

    // major opcodes handled by the front end
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // target functional unit
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MEM    = 2'd1,
        FU_BRANCH = 2'd2
    } fu_type_e;

    // decoded control word
    typedef struct packed {
        logic     has_dest;
        logic     uses_src1;
        logic     uses_src2;
        logic     rd_mem;
        logic     wr_mem;
        logic     cond_branch;
        logic     halt;
        logic     illegal;
        fu_type_e fu_type;
    } decode_t;

endpackage

// ==== rtl/map_table.sv ====
/*
 * register map table
 * architectural to physical mapping and one
 * ready bit per physical tag
 */
`include "rename_config.svh"

module map_table
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  arch_reg_t src1_arch_i,
    input  arch_reg_t src2_arch_i,
    output phys_tag_t src1_tag_o,
    output phys_tag_t src2_tag_o,
    output logic      src1_ready_o,
    output logic      src2_ready_o,
    input  arch_reg_t dest_arch_i,
    output phys_tag_t old_tag_o,
    input  logic      rename_i,
    input  phys_tag_t new_tag_i,
    input  logic      wb_valid_i,
    input  phys_tag_t wb_tag_i
);

    phys_tag_t              map_q [`ARCH_REGS];
    logic [`PHYS_REGS-1:0]  ready_q;

    // lookups see state before the edge
    assign src1_tag_o   = map_q[src1_arch_i];
    assign src2_tag_o   = map_q[src2_arch_i];
    assign src1_ready_o = ready_q[src1_tag_o];
    assign src2_ready_o = ready_q[src2_tag_o];
    assign old_tag_o    = map_q[dest_arch_i];

    always_ff @(posedge clock) begin
        if (!reset) begin
            // identity map, everything ready
            for (int r = 0; r < `ARCH_REGS; r++) begin
                map_q[r] <= phys_tag_t'(r);
            end
            ready_q <= '1;
        end else begin
            if (wb_valid_i) begin
                ready_q[wb_tag_i] <= 1'b1;
            end
            // rename after writeback, new tag goes pending
            if (rename_i) begin
                map_q[dest_arch_i] <= new_tag_i;
                ready_q[new_tag_i] <= 1'b0;
            end
        end
    end

    // x0 stays on tag 0, dispatch must filter it
    a_no_x0_rename: assert property (@(posedge clock) disable iff (!reset)
        rename_i |-> dest_arch_i != '0);

endmodule

// ==== rtl/rename_config.svh ====
/*
 * rename front end sizing
 * register file, ROB, reservation station
 * and free list capacities
 */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural and physical register counts
`define ARCH_REGS 32
`define PHYS_REGS 64

// in-flight window
`define ROB_DEPTH 16

// reservation station credits
`define RS_SLOTS 8

// tags not mapped at reset
`define FREE_DEPTH (`PHYS_REGS - `ARCH_REGS)

`endif

// ==== rtl/rename_dispatch.sv ====
/*
 * rename and dispatch front end top
 * free list and ROB FIFOs, map table, init
 * counter, control FSM and the dispatch stage
 */
`include "rename_config.svh"

module rename_dispatch
    import rename_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          fetch_valid_i,
    input  fetch_packet_t fetch_packet_i,
    input  logic          commit_i,
    input  logic          issue_i,
    input  logic          wb_valid_i,
    input  phys_tag_t     wb_tag_i,
    output logic          rs_valid_o,
    output rs_entry_t     rs_entry_o,
    output logic          stall_o,
    output logic          halted_o
);

    logic        count_en, init_push, init_done, run, halt_disp;
    disp_state_e state;
    phys_tag_t   init_tag, free_head, free_data;
    logic        free_push, free_pop, free_empty;
    logic        rob_push, rob_pop, rob_empty, rob_full;
    rob_entry_t  rob_head, rob_entry;
    rob_idx_t    rob_idx;
    arch_reg_t   src1_arch, src2_arch, dest_arch;
    phys_tag_t   src1_tag, src2_tag, old_tag;
    logic        src1_ready, src2_ready, rename;

    // ==============================
    // retire and free list refill
    // ==============================
    // commit on an empty ROB is dropped
    assign rob_pop   = commit_i && !rob_empty;
    // init fill and commit never overlap, tag 0 never freed
    assign free_push = init_push || (rob_pop && (rob_head.old_tag != '0));
    assign free_data = init_push ? init_tag : rob_head.old_tag;
    assign halted_o  = (state == HALTED);

    init_counter i_init_counter (
        .clock (clock), .reset (reset), .count_en_i (count_en),
        .tag_o (init_tag), .done_o (init_done)
    );

    dispatch_fsm i_dispatch_fsm (
        .clock (clock), .reset (reset), .init_done_i (init_done),
        .halt_dispatched_i (halt_disp), .rob_empty_i (rob_empty),
        .count_en_o (count_en), .init_push_o (init_push), .run_o (run), .state_o (state)
    );

    tag_fifo #(.payload_t(phys_tag_t), .DEPTH(`FREE_DEPTH)) i_free_list (
        .clock (clock), .reset (reset), .push_i (free_push), .push_data_i (free_data),
        .pop_i (free_pop), .head_o (free_head), .tail_idx_o (),
        .empty_o (free_empty), .full_o ()
    );

    tag_fifo #(.payload_t(rob_entry_t), .DEPTH(`ROB_DEPTH)) i_rob (
        .clock (clock), .reset (reset), .push_i (rob_push), .push_data_i (rob_entry),
        .pop_i (rob_pop), .head_o (rob_head), .tail_idx_o (rob_idx),
        .empty_o (rob_empty), .full_o (rob_full)
    );

    map_table i_map_table (
        .clock (clock), .reset (reset),
        .src1_arch_i (src1_arch), .src2_arch_i (src2_arch),
        .src1_tag_o (src1_tag), .src2_tag_o (src2_tag),
        .src1_ready_o (src1_ready), .src2_ready_o (src2_ready),
        .dest_arch_i (dest_arch), .old_tag_o (old_tag),
        .rename_i (rename), .new_tag_i (free_head),
        .wb_valid_i (wb_valid_i), .wb_tag_i (wb_tag_i)
    );

    dispatch_stage i_dispatch_stage (
        .clock (clock), .reset (reset),
        .fetch_valid_i (fetch_valid_i), .fetch_packet_i (fetch_packet_i),
        .run_i (run), .issue_i (issue_i),
        .free_empty_i (free_empty), .free_tag_i (free_head), .free_pop_o (free_pop),
        .src1_arch_o (src1_arch), .src2_arch_o (src2_arch),
        .src1_tag_i (src1_tag), .src2_tag_i (src2_tag),
        .src1_ready_i (src1_ready), .src2_ready_i (src2_ready),
        .dest_arch_o (dest_arch), .old_tag_i (old_tag), .rename_o (rename),
        .rob_full_i (rob_full), .rob_idx_i (rob_idx),
        .rob_push_o (rob_push), .rob_entry_o (rob_entry),
        .rs_valid_o (rs_valid_o), .rs_entry_o (rs_entry_o),
        .halt_o (halt_disp), .stall_o (stall_o)
    );

    // retire source must track the ROB
    a_no_commit_empty: assert property (@(posedge clock) disable iff (!reset)
        commit_i |-> !rob_empty);

endmodule

// ==== rtl/rename_pkg.sv ====
/*
 * rename and dispatch types
 * tags, fetch packet, ROB and RS entries
 * and the control state of the stage
 */
`include "rename_config.svh"

package rename_pkg;
    import isa_pkg::*;

    // ==============================
    // register and queue indices
    // ==============================
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // one fetched instruction
    typedef struct packed {
        inst_t       inst;
        logic [31:0] pc;
    } fetch_packet_t;

    // retire info, old_tag goes back to the free list
    typedef struct packed {
        arch_reg_t dest_arch;
        phys_tag_t old_tag;
        phys_tag_t new_tag;
    } rob_entry_t;

    // ==============================
    // reservation station entry
    // ==============================
    typedef struct packed {
        rob_idx_t    rob_idx;
        phys_tag_t   dest_tag;
        logic        dest_wen;
        phys_tag_t   src1_tag;
        logic        src1_ready;
        phys_tag_t   src2_tag;
        logic        src2_ready;
        fu_type_e    fu_type;
        logic [11:0] imm;
    } rs_entry_t;

    typedef enum logic [1:0] {
        INIT   = 2'd0,
        RUN    = 2'd1,
        DRAIN  = 2'd2,
        HALTED = 2'd3
    } disp_state_e;

endpackage

// ==== rtl/tag_fifo.sv ====
/*
 * circular FIFO with wrap bit
 * payload type is a parameter so the same
 * queue holds free tags and ROB entries
 */
module tag_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     push_i,
    input  payload_t                 push_data_i,
    input  logic                     pop_i,
    output payload_t                 head_o,
    output logic [$clog2(DEPTH)-1:0] tail_idx_o,
    output logic                     empty_o,
    output logic                     full_o
);

    localparam int AW = $clog2(DEPTH);

    payload_t    mem [DEPTH];
    // msb of each pointer is the wrap bit
    logic [AW:0] head_q;
    logic [AW:0] tail_q;

    assign head_o     = mem[head_q[AW-1:0]];
    assign tail_idx_o = tail_q[AW-1:0];
    assign empty_o    = (head_q == tail_q);
    assign full_o     = (head_q[AW-1:0] == tail_q[AW-1:0]) && (head_q[AW] != tail_q[AW]);

    // ==============================
    // pointers
    // ==============================
    always_ff @(posedge clock) begin
        if (!reset) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clock) begin
        if (push_i) begin
            mem[tail_q[AW-1:0]] <= push_data_i;
        end
    end

    // callers gate on full and empty
    a_no_push_full: assert property (@(posedge clock) disable iff (!reset)
        push_i |-> !full_o || pop_i);
    a_no_pop_empty: assert property (@(posedge clock) disable iff (!reset)
        pop_i |-> !empty_o);

endmodule

// ==== testbench/rename_stim.txt ====
# cmd letters: F fetch, C commit, I issue, W writeback, N idle, H wait for halt
# cmd inst_or_tag pc stall then expected RS entry: rob dtag wen s1 rdy1 s2 rdy2 fu imm
# dependent ALU chain, writeback of tag 0x20
F   00500093 00001000 0  0 20 1 00 1 00 1 0 005
F   00108113 00001004 0  1 21 1 20 0 00 1 0 001
W   00000020 00000000 0  0 00 0 00 0 00 0 0 000
F   002081b3 00001008 0  2 22 1 20 1 21 0 0 002
# store, branch and x0 write take no tag
F   0030a423 0000100c 0  3 00 0 20 1 22 0 1 008
F   00208863 00001010 0  4 00 0 20 1 21 0 2 010
F   00000013 00001014 0  5 00 0 00 1 00 1 0 000
F   00718213 00001018 0  6 23 1 22 0 00 1 0 007
# eighth dispatch uses the last RS credit
F   123452b7 0000101c 0  7 24 1 00 1 00 1 0 345
N   00000000 00000000 1  0 00 0 00 0 00 0 0 000
I   00000000 00000000 1  0 00 0 00 0 00 0 0 000
N   00000000 00000000 0  0 00 0 00 0 00 0 0 000
# fetch, issue and commit together, tags 0x25..0x3f then recycled tag 1
FIC 00100313 00001020 0  8 25 1 00 1 00 1 0 001
FIC 00100313 00001024 0  9 26 1 00 1 00 1 0 001
FIC 00100313 00001028 0  a 27 1 00 1 00 1 0 001
FIC 00100313 0000102c 0  b 28 1 00 1 00 1 0 001
FIC 00100313 00001030 0  c 29 1 00 1 00 1 0 001
FIC 00100313 00001034 0  d 2a 1 00 1 00 1 0 001
FIC 00100313 00001038 0  e 2b 1 00 1 00 1 0 001
FIC 00100313 0000103c 0  f 2c 1 00 1 00 1 0 001
FIC 00100313 00001040 0  0 2d 1 00 1 00 1 0 001
FIC 00100313 00001044 0  1 2e 1 00 1 00 1 0 001
FIC 00100313 00001048 0  2 2f 1 00 1 00 1 0 001
FIC 00100313 0000104c 0  3 30 1 00 1 00 1 0 001
FIC 00100313 00001050 0  4 31 1 00 1 00 1 0 001
FIC 00100313 00001054 0  5 32 1 00 1 00 1 0 001
FIC 00100313 00001058 0  6 33 1 00 1 00 1 0 001
FIC 00100313 0000105c 0  7 34 1 00 1 00 1 0 001
FIC 00100313 00001060 0  8 35 1 00 1 00 1 0 001
FIC 00100313 00001064 0  9 36 1 00 1 00 1 0 001
FIC 00100313 00001068 0  a 37 1 00 1 00 1 0 001
FIC 00100313 0000106c 0  b 38 1 00 1 00 1 0 001
FIC 00100313 00001070 0  c 39 1 00 1 00 1 0 001
FIC 00100313 00001074 0  d 3a 1 00 1 00 1 0 001
FIC 00100313 00001078 0  e 3b 1 00 1 00 1 0 001
FIC 00100313 0000107c 0  f 3c 1 00 1 00 1 0 001
FIC 00100313 00001080 0  0 3d 1 00 1 00 1 0 001
FIC 00100313 00001084 0  1 3e 1 00 1 00 1 0 001
FIC 00100313 00001088 0  2 3f 1 00 1 00 1 0 001
FIC 00100313 0000108c 0  3 01 1 00 1 00 1 0 001
# ebreak, then retire the remaining ROB entries
F   00100073 00001090 0  4 00 0 00 1 00 1 0 001
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
C   00000000 00000000 1  0 00 0 00 0 00 0 0 000
H   00000000 00000000 1  0 00 0 00 0 00 0 0 000
N   00000000 00000000 1  0 00 0 00 0 00 0 0 000
N   00000000 00000000 1  0 00 0 00 0 00 0 0 000

// ==== testbench/tb_rename_dispatch.sv ====
/*
 * testbench for the rename and dispatch front end
 * replays stim lines of fetch, commit, issue and
 * writeback strobes, checks stall, halt and RS entries
 */
`include "rename_config.svh"

module tb_rename_dispatch
    import isa_pkg::*;
    import rename_pkg::*;
();

    localparam int MAX_LINES = 80;
    localparam int HALT_WAIT = 64;

    logic          clock;
    logic          reset;
    logic          fetch_valid;
    fetch_packet_t fetch_packet;
    logic          commit;
    logic          issue;
    logic          wb_valid;
    phys_tag_t     wb_tag;
    logic          rs_valid;
    rs_entry_t     rs_entry;
    logic          stall;
    logic          halted;

    // parsed stim lines with one slot each
    logic [63:0] stim_cmd [MAX_LINES];
    logic [31:0] stim_a [MAX_LINES];
    logic [31:0] stim_b [MAX_LINES];
    logic        stim_stall [MAX_LINES];
    rs_entry_t   stim_rs [MAX_LINES];
    int          num_lines;
    int          cur_line;
    logic        stim_loaded;
    logic        halt_reached;

    int rs_errors;
    int valid_errors;
    int stall_errors;
    int halted_errors;
    int other_errors;

    rename_dispatch i_rename_dispatch (
        .clock          (clock),
        .reset          (reset),
        .fetch_valid_i  (fetch_valid),
        .fetch_packet_i (fetch_packet),
        .commit_i       (commit),
        .issue_i        (issue),
        .wb_valid_i     (wb_valid),
        .wb_tag_i       (wb_tag),
        .rs_valid_o     (rs_valid),
        .rs_entry_o     (rs_entry),
        .stall_o        (stall),
        .halted_o       (halted)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ==============================
    // compare tasks
    // ==============================
    task check_rs(input rs_entry_t got, input rs_entry_t exp);
        if (got !== exp) begin
            rs_errors++;
            $display("error: rs_entry_o step %0d got 0x%h expected 0x%h", cur_line, got, exp);
        end
    endtask

    task check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            valid_errors++;
            $display("error: rs_valid_o step %0d got 0x%h expected 0x%h", cur_line, got, exp);
        end
    endtask

    task check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            stall_errors++;
            $display("error: stall_o step %0d got 0x%h expected 0x%h", cur_line, got, exp);
        end
    endtask

    task check_halted(input logic got, input logic exp);
        if (got !== exp) begin
            halted_errors++;
            $display("error: halted_o step %0d got 0x%h expected 0x%h", cur_line, got, exp);
        end
    endtask

    function automatic int total_errors();
        return rs_errors + valid_errors + stall_errors + halted_errors + other_errors;
    endfunction

    task report_counts();
        $display("errors: rs_entry %0d, rs_valid %0d, stall %0d, halted %0d, other %0d",
                 rs_errors, valid_errors, stall_errors, halted_errors, other_errors);
    endtask

    // command tokens may combine letters such as FIC
    function automatic logic has_letter(input logic [63:0] tok, input logic [7:0] ch);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (tok[i*8 +: 8] == ch) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // ==============================
    // stim file reader
    // ==============================
    task load_stim();
        int          fd;
        int          code;
        logic        eof_seen;
        logic [63:0] tok;
        logic [31:0] fld [12];
        logic [2047:0] rest;
        rs_entry_t   exp;
        num_lines = 0;
        eof_seen  = 1'b0;
        fd = $fopen("testbench/rename_stim.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the stim file testbench/rename_stim.txt");
            eof_seen = 1'b1;
        end
        while (!eof_seen && num_lines < MAX_LINES) begin
            tok  = '0;
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                eof_seen = 1'b1;
            end else if (tok == "#") begin
                // skip the column notes to end of line
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                               fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                               fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]);
                if (code != 12) begin
                    other_errors++;
                    $display("stim line %0d is missing fields", num_lines);
                    eof_seen = 1'b1;
                end else begin
                    exp.rob_idx    = fld[3][3:0];
                    exp.dest_tag   = fld[4][5:0];
                    exp.dest_wen   = fld[5][0];
                    exp.src1_tag   = fld[6][5:0];
                    exp.src1_ready = fld[7][0];
                    exp.src2_tag   = fld[8][5:0];
                    exp.src2_ready = fld[9][0];
                    exp.fu_type    = fu_type_e'(fld[10][1:0]);
                    exp.imm        = fld[11][11:0];
                    stim_cmd[num_lines]   = tok;
                    stim_a[num_lines]     = fld[0];
                    stim_b[num_lines]     = fld[1];
                    stim_stall[num_lines] = fld[2][0];
                    stim_rs[num_lines]    = exp;
                    num_lines++;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    // one stim line from falling edge to falling edge
    task run_line(input int n);
        int waited;
        cur_line = n;
        check_stall(stall, stim_stall[n]);
        // halted_o low until the drain ends, then it holds
        if (!has_letter(stim_cmd[n], "H")) begin
            check_halted(halted, halt_reached);
        end
        if (has_letter(stim_cmd[n], "F")) begin
            fetch_valid  = 1'b1;
            fetch_packet = {stim_a[n], stim_b[n]};
        end
        commit = has_letter(stim_cmd[n], "C");
        issue  = has_letter(stim_cmd[n], "I");
        if (has_letter(stim_cmd[n], "W")) begin
            wb_valid = 1'b1;
            wb_tag   = stim_a[n][5:0];
        end
        if (has_letter(stim_cmd[n], "H")) begin
            waited = 0;
            while (!halted && waited < HALT_WAIT) begin
                @(negedge clock);
                waited++;
            end
            if (!halted) begin
                other_errors++;
                $display("halted_o did not rise within %0d cycles at step %0d", HALT_WAIT, n);
            end
            check_halted(halted, 1'b1);
            halt_reached = 1'b1;
        end else begin
            @(negedge clock);
            fetch_valid = 1'b0;
            commit      = 1'b0;
            issue       = 1'b0;
            wb_valid    = 1'b0;
            // registered RS entry shows one cycle after the fetch
            check_valid(rs_valid, has_letter(stim_cmd[n], "F"));
            if (has_letter(stim_cmd[n], "F")) begin
                check_rs(rs_entry, stim_rs[n]);
            end
        end
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int waited;
        reset         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_packet  = '0;
        commit        = 1'b0;
        issue         = 1'b0;
        wb_valid      = 1'b0;
        wb_tag        = '0;
        rs_errors     = 0;
        valid_errors  = 0;
        stall_errors  = 0;
        halted_errors = 0;
        other_errors  = 0;
        cur_line      = -1;
        stim_loaded   = 1'b0;
        halt_reached  = 1'b0;
        load_stim();
        stim_loaded = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b1;
        // state right after reset
        check_stall(stall, 1'b1);
        check_halted(halted, 1'b0);
        check_valid(rs_valid, 1'b0);
        // stall drops once the free list fill is done
        waited = 0;
        while (stall && waited < 2 * `PHYS_REGS) begin
            @(negedge clock);
            waited++;
        end
        if (stall) begin
            other_errors++;
            $display("stall_o stayed high after the free list fill");
        end else if (waited < `FREE_DEPTH) begin
            other_errors++;
            $display("stall_o dropped after %0d cycles, before the free list was full", waited);
        end
        for (int n = 0; n < num_lines; n++) begin
            run_line(n);
        end
        report_counts();
        if (total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog budget scales with the stim length
    initial begin
        wait (stim_loaded);
        repeat (num_lines * 20 + 64) @(posedge clock);
        $display("timeout: run still going after %0d cycles", num_lines * 20 + 64);
        report_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
